// ==== verilog/host_chan_pkg.sv ====
`default_nettype none

package host_chan_pkg;

    // Host MMIO addresses count 32-bit dwords
    localparam int MMIO_ADDR_WIDTH = 16;

    // Tag width returned with each MMIO read response
    localparam int MMIO_TID_WIDTH = 9;

    // CSRs are 64 bits wide
    localparam int MMIO_DATA_WIDTH = 64;

    // Memory requests address whole cache lines
    localparam int LINE_ADDR_WIDTH = 32;

    // MMIO dword address
    typedef logic [MMIO_ADDR_WIDTH-1:0] t_mmio_addr;

    // MMIO transaction tag
    typedef logic [MMIO_TID_WIDTH-1:0] t_mmio_tid;

    // CSR read and write data
    typedef logic [MMIO_DATA_WIDTH-1:0] t_mmio_data;

    // Cache-line address, also used as the write payload
    typedef logic [LINE_ADDR_WIDTH-1:0] t_line_addr;

    // Direction of a request and of its response
    typedef enum logic
    {
        REQ_READ  = 1'b0,
        REQ_WRITE = 1'b1
    } t_req_kind;

endpackage

`default_nettype wire

// ==== verilog/test_csr_pkg.sv ====
`default_nettype none

package test_csr_pkg;

    // Statistics counters, wide enough never to wrap in a test
    typedef logic [47:0] t_test_counter;

    // Accelerator identifier, read as two 64-bit halves
    localparam logic [127:0] AFU_ID = 128'h5c2e_91a7_04d3_4b6f_a81e_3f70_c29d_6e15;

    // Feature type field of the device-feature header
    localparam logic [3:0] DFH_TYPE_AFU = 4'h1;

    // Standard CSR indices, in 64-bit units
    localparam int CSR_DFH       = 0;
    localparam int CSR_ID_L      = 1;
    localparam int CSR_ID_H      = 2;
    localparam int CSR_RSVD0     = 3;
    localparam int CSR_RSVD1     = 4;
    localparam int CSR_FREQ      = 8;
    localparam int CSR_RD_HIT    = 9;
    localparam int CSR_RD_MISS   = 10;
    localparam int CSR_WR_HIT    = 11;
    localparam int CSR_WR_MISS   = 12;
    localparam int CSR_VL0       = 13;
    localparam int CSR_TEST_BASE = 32;

    // Test-CSR slots, relative to CSR_TEST_BASE
    localparam int TCSR_RD_CTRL = 0;
    localparam int TCSR_WR_CTRL = 1;
    localparam int TCSR_RD_BASE = 2;
    localparam int TCSR_WR_BASE = 3;

    // Traffic engine FSM
    typedef enum logic [1:0]
    {
        ENG_IDLE  = 2'd0,
        ENG_ISSUE = 2'd1,
        ENG_DRAIN = 2'd2
    } t_engine_state;

endpackage

`default_nettype wire

// ==== verilog/afu_ifs.sv ====
`default_nettype none

// Test-CSR bus between the CSR manager and the traffic engines
interface test_csr_if
#(
    parameter int NUM_TEST_CSRS = 4
);
    import host_chan_pkg::*;

    // One write strobe per slot, single cycle
    logic [NUM_TEST_CSRS-1:0] wr_en;

    // Write data is common to all slots
    t_mmio_data wr_data;

    // Value returned on a host read of each slot
    t_mmio_data rd_data [NUM_TEST_CSRS];

    // CSR manager side
    modport csr
    (
        output wr_en,
        output wr_data,
        input  rd_data
    );

    // Engine side, each engine drives only the slots it owns
    modport engine
    (
        input  wr_en,
        input  wr_data,
        output rd_data
    );

endinterface

// Request stream from one engine into the arbiter
interface mem_req_if;
    import host_chan_pkg::*;

    // Level, held with stable fields until granted
    logic valid;
    t_req_kind kind;
    t_line_addr addr;
    t_line_addr data;

    // Single-cycle grant pulse from the arbiter
    logic grant;

    modport engine
    (
        output valid,
        output kind,
        output addr,
        output data,
        input  grant
    );

    modport arbiter
    (
        input  valid,
        input  kind,
        input  addr,
        input  data,
        output grant
    );

endinterface

`default_nettype wire

// ==== verilog/csr_manager.sv ====
`default_nettype none

module csr_manager
#(
    parameter int NUM_TEST_CSRS = 4,
    parameter int NEXT_DFH_BYTE_OFFSET = 0,
    parameter int AFU_CLOCK_MHZ = 400
)
(
    input  wire logic clk,
    input  wire logic reset,

    // Host MMIO requests
    input  wire logic mmio_valid,
    input  wire logic mmio_write,
    input  wire host_chan_pkg::t_mmio_addr mmio_addr,
    input  wire host_chan_pkg::t_mmio_tid mmio_tid,
    input  wire host_chan_pkg::t_mmio_data mmio_wdata,

    // Host responses, observed for statistics only
    input  wire logic rsp_valid,
    input  wire host_chan_pkg::t_req_kind rsp_kind,
    input  wire logic rsp_hit,
    input  wire logic rsp_vl0,

    // MMIO read response
    output logic mmio_rsp_valid,
    output host_chan_pkg::t_mmio_tid mmio_rsp_tid,
    output host_chan_pkg::t_mmio_data mmio_rsp_data,

    test_csr_if.csr csrs
);
    import host_chan_pkg::*;
    import test_csr_pkg::*;

    // Local CSR space covers the standard block plus the test slots
    localparam int MAX_CSR = CSR_TEST_BASE + NUM_TEST_CSRS;
    localparam int IDX_W = $clog2(MAX_CSR);
    localparam int SLOT_W = (NUM_TEST_CSRS > 1) ? $clog2(NUM_TEST_CSRS) : 1;

    // DFH: AFU type on top, next-feature offset in 39:16
    localparam t_mmio_data DFH_VALUE =
        {DFH_TYPE_AFU, 20'h0, 24'(NEXT_DFH_BYTE_OFFSET), 16'h0};

    // Registered MMIO request
    logic mmio_valid_q;
    logic mmio_write_q;
    t_mmio_addr mmio_addr_q;
    t_mmio_tid mmio_tid_q;
    t_mmio_data mmio_wdata_q;

    // Registered response flags
    logic rsp_valid_q;
    t_req_kind rsp_kind_q;
    logic rsp_hit_q;
    logic rsp_vl0_q;
    logic vl0_seen_q;

    logic in_range;
    logic [IDX_W-1:0] csr_idx;
    logic [SLOT_W-1:0] test_slot;
    t_mmio_data rd_value;

    t_test_counter ctr_rd_hit;
    t_test_counter ctr_rd_miss;
    t_test_counter ctr_wr_hit;
    t_test_counter ctr_wr_miss;
    t_test_counter ctr_vl0;

    always_ff @(posedge clk)
    begin
        mmio_write_q <= mmio_write;
        mmio_addr_q <= mmio_addr;
        mmio_tid_q <= mmio_tid;
        mmio_wdata_q <= mmio_wdata;
        rsp_kind_q <= rsp_kind;
        rsp_hit_q <= rsp_hit;
        rsp_vl0_q <= rsp_vl0;

        if (reset)
        begin
            mmio_valid_q <= 1'b0;
            rsp_valid_q <= 1'b0;
        end
        else
        begin
            mmio_valid_q <= mmio_valid;
            rsp_valid_q <= rsp_valid;
        end
    end

    // Range check once, then drop to a 64-bit CSR index
    assign in_range = (mmio_addr_q < t_mmio_addr'(2 * MAX_CSR));
    assign csr_idx = mmio_addr_q[1 +: IDX_W];
    assign test_slot = SLOT_W'(csr_idx - IDX_W'(CSR_TEST_BASE));

    // Read mux, unlisted slots return zero
    always_comb
    begin
        rd_value = '0;
        case (int'(csr_idx))
            CSR_DFH:     rd_value = DFH_VALUE;
            CSR_ID_L:    rd_value = AFU_ID[63:0];
            CSR_ID_H:    rd_value = AFU_ID[127:64];
            CSR_RSVD0:   rd_value = '0;
            CSR_RSVD1:   rd_value = '0;
            CSR_FREQ:    rd_value = t_mmio_data'(AFU_CLOCK_MHZ);
            CSR_RD_HIT:  rd_value = t_mmio_data'(ctr_rd_hit);
            CSR_RD_MISS: rd_value = t_mmio_data'(ctr_rd_miss);
            CSR_WR_HIT:  rd_value = t_mmio_data'(ctr_wr_hit);
            CSR_WR_MISS: rd_value = t_mmio_data'(ctr_wr_miss);
            CSR_VL0:     rd_value = t_mmio_data'(ctr_vl0);
            default:
            begin
                // Test slots come from the engines
                if (int'(csr_idx) >= CSR_TEST_BASE && int'(csr_idx) < MAX_CSR)
                begin
                    rd_value = csrs.rd_data[test_slot];
                end
            end
        endcase
    end

    // Read response, second register stage
    always_ff @(posedge clk)
    begin
        mmio_rsp_tid <= mmio_tid_q;
        mmio_rsp_data <= rd_value;
        if (reset)
        begin
            mmio_rsp_valid <= 1'b0;
        end
        else
        begin
            mmio_rsp_valid <= mmio_valid_q && !mmio_write_q && in_range;
        end
    end

    // Write fan-out, data to all slots and a strobe to the addressed one
    always_ff @(posedge clk)
    begin
        csrs.wr_data <= mmio_wdata_q;
        for (int i = 0; i < NUM_TEST_CSRS; i++)
        begin
            csrs.wr_en[i] <= mmio_valid_q && mmio_write_q && in_range &&
                             (int'(csr_idx) == CSR_TEST_BASE + i);
        end
        if (reset)
        begin
            csrs.wr_en <= '0;
        end
    end

    // Statistics, VL0 goes through one extra stage
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ctr_rd_hit <= '0;
            ctr_rd_miss <= '0;
            ctr_wr_hit <= '0;
            ctr_wr_miss <= '0;
            ctr_vl0 <= '0;
            vl0_seen_q <= 1'b0;
        end
        else
        begin
            if (rsp_valid_q && rsp_kind_q == REQ_READ)
            begin
                if (rsp_hit_q)
                    ctr_rd_hit <= ctr_rd_hit + 1'b1;
                else
                    ctr_rd_miss <= ctr_rd_miss + 1'b1;
            end
            if (rsp_valid_q && rsp_kind_q == REQ_WRITE)
            begin
                if (rsp_hit_q)
                    ctr_wr_hit <= ctr_wr_hit + 1'b1;
                else
                    ctr_wr_miss <= ctr_wr_miss + 1'b1;
            end
            vl0_seen_q <= rsp_valid_q && rsp_vl0_q;
            ctr_vl0 <= ctr_vl0 + t_test_counter'(vl0_seen_q);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/traffic_engine.sv ====
`default_nettype none

module traffic_engine
#(
    parameter bit IS_WRITE = 1'b0
)
(
    input  wire logic clk,
    input  wire logic reset,

    // Host responses, shared by both engines
    input  wire logic rsp_valid,
    input  wire host_chan_pkg::t_req_kind rsp_kind,

    test_csr_if.engine csrs,
    mem_req_if.engine req
);
    import host_chan_pkg::*;
    import test_csr_pkg::*;

    // Slots and request kind owned by this engine
    localparam int CTRL_SLOT = IS_WRITE ? TCSR_WR_CTRL : TCSR_RD_CTRL;
    localparam int BASE_SLOT = IS_WRITE ? TCSR_WR_BASE : TCSR_RD_BASE;
    localparam t_req_kind ENG_KIND = IS_WRITE ? REQ_WRITE : REQ_READ;

    t_engine_state state;
    t_line_addr base_addr;
    t_line_addr cur_addr;
    logic [31:0] target;
    logic [31:0] issued;
    logic [31:0] rsp_cnt;
    logic done;
    logic rsp_match;

    assign rsp_match = rsp_valid && (rsp_kind == ENG_KIND);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= ENG_IDLE;
            base_addr <= '0;
            cur_addr <= '0;
            target <= '0;
            issued <= '0;
            rsp_cnt <= '0;
            done <= 1'b0;
        end
        else
        begin
            // Base can be changed at any time, it applies on the next start
            if (csrs.wr_en[BASE_SLOT])
                base_addr <= t_line_addr'(csrs.wr_data);

            // Count matching responses while a run is active
            if (state != ENG_IDLE && rsp_match)
                rsp_cnt <= rsp_cnt + 1'b1;

            case (state)
                ENG_IDLE:
                begin
                    if (csrs.wr_en[CTRL_SLOT])
                    begin
                        // Start, count comes from the low word
                        target <= csrs.wr_data[31:0];
                        cur_addr <= base_addr;
                        issued <= '0;
                        rsp_cnt <= '0;
                        done <= (csrs.wr_data[31:0] == '0);
                        if (csrs.wr_data[31:0] != '0)
                            state <= ENG_ISSUE;
                    end
                end
                ENG_ISSUE:
                begin
                    // Advance only on the grant edge
                    if (req.grant)
                    begin
                        cur_addr <= cur_addr + 1'b1;
                        issued <= issued + 1'b1;
                        if (issued == target - 1'b1)
                            state <= ENG_DRAIN;
                    end
                end
                ENG_DRAIN:
                begin
                    // All responses back
                    if (rsp_cnt == target)
                    begin
                        done <= 1'b1;
                        state <= ENG_IDLE;
                    end
                end
                default: state <= ENG_IDLE;
            endcase
        end
    end

    // Request fields held stable while in ISSUE
    assign req.valid = (state == ENG_ISSUE);
    assign req.kind = ENG_KIND;
    assign req.addr = cur_addr;
    // Writes carry their own line address as payload
    assign req.data = IS_WRITE ? cur_addr : '0;

    // Done in bit 63 and the response count below
    assign csrs.rd_data[CTRL_SLOT] = {done, 31'h0, rsp_cnt};
    assign csrs.rd_data[BASE_SLOT] = t_mmio_data'(base_addr);

endmodule

`default_nettype wire

// ==== verilog/request_arbiter.sv ====
`default_nettype none

module request_arbiter
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic req_almfull,

    mem_req_if.arbiter rd,
    mem_req_if.arbiter wr,

    // Host request channel
    output logic req_valid,
    output host_chan_pkg::t_req_kind req_kind,
    output host_chan_pkg::t_line_addr req_addr,
    output host_chan_pkg::t_line_addr req_data
);
    // Priority to the writer when set
    logic prio_wr;
    logic rd_ok;
    logic wr_ok;
    logic pick_wr;
    logic any_ok;

    // A requester granted last cycle still shows its old fields, so skip it
    assign rd_ok = rd.valid && !rd.grant && !req_almfull;
    assign wr_ok = wr.valid && !wr.grant && !req_almfull;
    assign any_ok = rd_ok || wr_ok;
    assign pick_wr = wr_ok && (!rd_ok || prio_wr);

    always_ff @(posedge clk)
    begin
        // Winning fields go straight onto the host channel
        req_kind <= pick_wr ? wr.kind : rd.kind;
        req_addr <= pick_wr ? wr.addr : rd.addr;
        req_data <= pick_wr ? wr.data : rd.data;

        if (reset)
        begin
            req_valid <= 1'b0;
            rd.grant <= 1'b0;
            wr.grant <= 1'b0;
            prio_wr <= 1'b0;
        end
        else
        begin
            req_valid <= any_ok;
            rd.grant <= any_ok && !pick_wr;
            wr.grant <= pick_wr;
            // Flip toward the loser after each grant
            if (any_ok)
                prio_wr <= !pick_wr;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/afu_test_top.sv ====
`default_nettype none

module afu_test_top
#(
    parameter int NUM_TEST_CSRS = 4,
    parameter int NEXT_DFH_BYTE_OFFSET = 0,
    parameter int AFU_CLOCK_MHZ = 400
)
(
    input  wire logic clk,
    input  wire logic reset,

    // Host MMIO
    input  wire logic mmio_valid,
    input  wire logic mmio_write,
    input  wire host_chan_pkg::t_mmio_addr mmio_addr,
    input  wire host_chan_pkg::t_mmio_tid mmio_tid,
    input  wire host_chan_pkg::t_mmio_data mmio_wdata,
    output logic mmio_rsp_valid,
    output host_chan_pkg::t_mmio_tid mmio_rsp_tid,
    output host_chan_pkg::t_mmio_data mmio_rsp_data,

    // Host request channel
    output logic req_valid,
    output host_chan_pkg::t_req_kind req_kind,
    output host_chan_pkg::t_line_addr req_addr,
    output host_chan_pkg::t_line_addr req_data,
    input  wire logic req_almfull,

    // Host response channel
    input  wire logic rsp_valid,
    input  wire host_chan_pkg::t_req_kind rsp_kind,
    input  wire logic rsp_hit,
    input  wire logic rsp_vl0
);
    test_csr_if #(.NUM_TEST_CSRS(NUM_TEST_CSRS)) csrs_if ();
    mem_req_if rd_req_if ();
    mem_req_if wr_req_if ();

    csr_manager
    #(
        .NUM_TEST_CSRS(NUM_TEST_CSRS),
        .NEXT_DFH_BYTE_OFFSET(NEXT_DFH_BYTE_OFFSET),
        .AFU_CLOCK_MHZ(AFU_CLOCK_MHZ)
    )
    csr_manager_inst
    (
        .clk(clk),
        .reset(reset),
        .mmio_valid(mmio_valid),
        .mmio_write(mmio_write),
        .mmio_addr(mmio_addr),
        .mmio_tid(mmio_tid),
        .mmio_wdata(mmio_wdata),
        .rsp_valid(rsp_valid),
        .rsp_kind(rsp_kind),
        .rsp_hit(rsp_hit),
        .rsp_vl0(rsp_vl0),
        .mmio_rsp_valid(mmio_rsp_valid),
        .mmio_rsp_tid(mmio_rsp_tid),
        .mmio_rsp_data(mmio_rsp_data),
        .csrs(csrs_if.csr)
    );

    // Line reader
    traffic_engine #(.IS_WRITE(1'b0)) reader_inst
    (
        .clk(clk),
        .reset(reset),
        .rsp_valid(rsp_valid),
        .rsp_kind(rsp_kind),
        .csrs(csrs_if.engine),
        .req(rd_req_if.engine)
    );

    // Line writer
    traffic_engine #(.IS_WRITE(1'b1)) writer_inst
    (
        .clk(clk),
        .reset(reset),
        .rsp_valid(rsp_valid),
        .rsp_kind(rsp_kind),
        .csrs(csrs_if.engine),
        .req(wr_req_if.engine)
    );

    request_arbiter request_arbiter_inst
    (
        .clk(clk),
        .reset(reset),
        .req_almfull(req_almfull),
        .rd(rd_req_if.arbiter),
        .wr(wr_req_if.arbiter),
        .req_valid(req_valid),
        .req_kind(req_kind),
        .req_addr(req_addr),
        .req_data(req_data)
    );

endmodule

`default_nettype wire

// ==== tb/host_mem_model.sv ====
`default_nettype none

module host_mem_model
(
    input  wire logic clk,
    input  wire logic reset,
    // Enables the almost-full windows
    input  wire logic stress,
    input  wire logic req_valid,
    input  wire host_chan_pkg::t_req_kind req_kind,
    input  wire host_chan_pkg::t_line_addr req_addr,
    input  wire host_chan_pkg::t_line_addr req_data,
    output logic req_almfull,
    output logic rsp_valid,
    output host_chan_pkg::t_req_kind rsp_kind,
    output logic rsp_hit,
    output logic rsp_vl0
);
    import host_chan_pkg::*;

    localparam int LOG_DEPTH = 256;

    // Every request seen on the host channel, in arrival order
    t_req_kind seen_kind [LOG_DEPTH];
    t_line_addr seen_addr [LOG_DEPTH];
    t_line_addr seen_data [LOG_DEPTH];
    int seen_count;
    // Requests that arrived after two almost-full cycles
    int almfull_violations;

    // Pending responses and the cycle each one is due
    t_req_kind pend_kind [$];
    t_line_addr pend_addr [$];
    longint pend_due [$];
    longint cycle;
    longint last_due;
    logic almfull_q;

    initial
    begin
        req_almfull = 1'b0;
        rsp_valid = 1'b0;
        rsp_kind = REQ_READ;
        rsp_hit = 1'b0;
        rsp_vl0 = 1'b0;
    end

    always @(posedge clk)
    begin
        longint due;
        if (reset)
        begin
            pend_kind.delete();
            pend_addr.delete();
            pend_due.delete();
            seen_count = 0;
            almfull_violations = 0;
            cycle = 0;
            last_due = 0;
            almfull_q <= 1'b0;
            req_almfull <= 1'b0;
            rsp_valid <= 1'b0;
        end
        else
        begin
            cycle = cycle + 1;
            if (req_valid)
            begin
                if (req_almfull && almfull_q)
                    almfull_violations = almfull_violations + 1;
                if (seen_count < LOG_DEPTH)
                begin
                    seen_kind[seen_count] = req_kind;
                    seen_addr[seen_count] = req_addr;
                    seen_data[seen_count] = req_data;
                end
                seen_count = seen_count + 1;
                // Latency varies with the address, order is kept
                due = cycle + 3 + longint'(req_addr % 3);
                if (due <= last_due)
                    due = last_due + 1;
                last_due = due;
                pend_kind.push_back(req_kind);
                pend_addr.push_back(req_addr);
                pend_due.push_back(due);
            end

            // At most one response per cycle
            rsp_valid <= 1'b0;
            if (pend_due.size() > 0 && pend_due[0] <= cycle)
            begin
                rsp_valid <= 1'b1;
                rsp_kind <= pend_kind[0];
                // Hit from address bit 0, VL0 when bit 1 is clear
                rsp_hit <= pend_addr[0][0];
                rsp_vl0 <= !pend_addr[0][1];
                void'(pend_kind.pop_front());
                void'(pend_addr.pop_front());
                void'(pend_due.pop_front());
            end

            almfull_q <= req_almfull;
            // Three cycles high out of every seven
            req_almfull <= stress && (cycle % 7 < 3);
        end
    end

endmodule

`default_nettype wire

// ==== tb/afu_test_tb.sv ====
`default_nettype none

module afu_test_tb;
    import host_chan_pkg::*;
    import test_csr_pkg::*;

    localparam int NUM_TEST_CSRS = 4;
    localparam int NEXT_DFH_BYTE_OFFSET = 0;
    localparam int AFU_CLOCK_MHZ = 400;
    localparam int RSP_TIMEOUT = 20;
    localparam int DONE_POLLS = 200;

    logic clk;
    logic reset;
    logic mmio_valid;
    logic mmio_write;
    t_mmio_addr mmio_addr;
    t_mmio_tid mmio_tid;
    t_mmio_data mmio_wdata;
    logic mmio_rsp_valid;
    t_mmio_tid mmio_rsp_tid;
    t_mmio_data mmio_rsp_data;
    logic req_valid;
    t_req_kind req_kind;
    t_line_addr req_addr;
    t_line_addr req_data;
    logic req_almfull;
    logic rsp_valid;
    t_req_kind rsp_kind;
    logic rsp_hit;
    logic rsp_vl0;
    logic stress;

    // Expected statistics built from the chosen addresses
    int exp_rd_hit;
    int exp_rd_miss;
    int exp_wr_hit;
    int exp_wr_miss;
    int exp_vl0;
    t_mmio_tid next_tid;

    afu_test_top
    #(
        .NUM_TEST_CSRS(NUM_TEST_CSRS),
        .NEXT_DFH_BYTE_OFFSET(NEXT_DFH_BYTE_OFFSET),
        .AFU_CLOCK_MHZ(AFU_CLOCK_MHZ)
    )
    afu_test_top_inst
    (
        .clk(clk),
        .reset(reset),
        .mmio_valid(mmio_valid),
        .mmio_write(mmio_write),
        .mmio_addr(mmio_addr),
        .mmio_tid(mmio_tid),
        .mmio_wdata(mmio_wdata),
        .mmio_rsp_valid(mmio_rsp_valid),
        .mmio_rsp_tid(mmio_rsp_tid),
        .mmio_rsp_data(mmio_rsp_data),
        .req_valid(req_valid),
        .req_kind(req_kind),
        .req_addr(req_addr),
        .req_data(req_data),
        .req_almfull(req_almfull),
        .rsp_valid(rsp_valid),
        .rsp_kind(rsp_kind),
        .rsp_hit(rsp_hit),
        .rsp_vl0(rsp_vl0)
    );

    host_mem_model host_mem_model_inst
    (
        .clk(clk),
        .reset(reset),
        .stress(stress),
        .req_valid(req_valid),
        .req_kind(req_kind),
        .req_addr(req_addr),
        .req_data(req_data),
        .req_almfull(req_almfull),
        .rsp_valid(rsp_valid),
        .rsp_kind(rsp_kind),
        .rsp_hit(rsp_hit),
        .rsp_vl0(rsp_vl0)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
        if (actual !== expected)
            abort_run($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
    endtask

    // One MMIO write cycle plus room for the strobe and the engine edge
    task automatic csr_write(input int idx, input t_mmio_data data);
        @(posedge clk);
        mmio_valid <= 1'b1;
        mmio_write <= 1'b1;
        mmio_addr <= t_mmio_addr'(2 * idx);
        mmio_wdata <= data;
        @(posedge clk);
        mmio_valid <= 1'b0;
        mmio_write <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    // One MMIO read cycle, returns on the edge where the DUT samples it
    task automatic issue_read(input int idx, input t_mmio_tid tid);
        @(posedge clk);
        mmio_valid <= 1'b1;
        mmio_write <= 1'b0;
        mmio_addr <= t_mmio_addr'(2 * idx);
        mmio_tid <= tid;
        @(posedge clk);
        mmio_valid <= 1'b0;
    endtask

    task automatic csr_read(input int idx, output t_mmio_data data);
        t_mmio_tid tid;
        int waited;
        tid = next_tid;
        next_tid = next_tid + 1'b1;
        issue_read(idx, tid);
        // Sampled mid-cycle
        @(negedge clk);
        waited = 1;
        while (!mmio_rsp_valid && waited < RSP_TIMEOUT)
        begin
            @(negedge clk);
            waited++;
        end
        if (!mmio_rsp_valid)
            abort_run($sformatf("No MMIO read response for CSR %0d", idx));
        check("mmio_rsp_latency", 64'(waited), 64'd2);
        check("mmio_rsp_tid", 64'(mmio_rsp_tid), 64'(tid));
        data = mmio_rsp_data;
    endtask

    task automatic read_no_response(input int idx);
        int waited;
        issue_read(idx, next_tid);
        waited = 0;
        while (waited < RSP_TIMEOUT)
        begin
            @(negedge clk);
            if (mmio_rsp_valid)
                abort_run($sformatf("Out-of-range read of CSR %0d got a response", idx));
            waited++;
        end
    endtask

    // Base then count, and account the model's hit and VL0 rule
    task automatic start_run(input bit is_write, input t_line_addr base, input int count);
        t_line_addr addr;
        csr_write(CSR_TEST_BASE + (is_write ? TCSR_WR_BASE : TCSR_RD_BASE), t_mmio_data'(base));
        csr_write(CSR_TEST_BASE + (is_write ? TCSR_WR_CTRL : TCSR_RD_CTRL), t_mmio_data'(count));
        for (int i = 0; i < count; i++)
        begin
            addr = base + t_line_addr'(i);
            if (is_write && addr[0])
                exp_wr_hit++;
            else if (is_write)
                exp_wr_miss++;
            else if (addr[0])
                exp_rd_hit++;
            else
                exp_rd_miss++;
            if (!addr[1])
                exp_vl0++;
        end
    endtask

    // Poll the ctrl slot until done and check the response count
    task automatic wait_done(input int idx, input int count);
        t_mmio_data value;
        int polls;
        value = '0;
        polls = 0;
        while (!value[63] && polls < DONE_POLLS)
        begin
            csr_read(idx, value);
            polls++;
        end
        if (!value[63])
            abort_run($sformatf("Engine at CSR %0d never reported done", idx));
        check($sformatf("csr%0d", idx), value, {1'b1, 31'h0, 32'(count)});
    endtask

    // Requests of one kind from log entry first on must count up from base
    task automatic check_log(input t_req_kind kind, input t_line_addr base,
                             input int count, input int first);
        t_line_addr expect_addr;
        int found;
        found = 0;
        for (int i = first; i < host_mem_model_inst.seen_count; i++)
        begin
            if (host_mem_model_inst.seen_kind[i] == kind)
            begin
                expect_addr = base + t_line_addr'(found);
                check("req_addr", 64'(host_mem_model_inst.seen_addr[i]), 64'(expect_addr));
                if (kind == REQ_WRITE)
                    check("req_data", 64'(host_mem_model_inst.seen_data[i]), 64'(expect_addr));
                found++;
            end
        end
        check("request_count", 64'(found), 64'(count));
    endtask

    task automatic header_reads();
        t_mmio_data value;
        @(negedge clk);
        check("req_valid", 64'(req_valid), 64'd0);
        check("mmio_rsp_valid", 64'(mmio_rsp_valid), 64'd0);
        csr_read(CSR_DFH, value);
        // AFU feature type 1 in 63:60 and the next offset in 39:16
        check("csr0", value, (64'h1 << 60) | (64'(NEXT_DFH_BYTE_OFFSET) << 16));
        csr_read(CSR_ID_L, value);
        check("csr1", value, AFU_ID[63:0]);
        csr_read(CSR_ID_H, value);
        check("csr2", value, AFU_ID[127:64]);
        csr_read(CSR_RSVD0, value);
        check("csr3", value, 64'd0);
        csr_read(CSR_RSVD1, value);
        check("csr4", value, 64'd0);
        csr_read(7, value);
        check("csr7", value, 64'd0);
        csr_read(CSR_FREQ, value);
        check("csr8", value, 64'(AFU_CLOCK_MHZ));
        for (int idx = CSR_RD_HIT; idx <= CSR_VL0; idx++)
        begin
            csr_read(idx, value);
            check($sformatf("csr%0d", idx), value, 64'd0);
        end
        // Beyond the test slots
        read_no_response(CSR_TEST_BASE + NUM_TEST_CSRS + 4);
    endtask

    task automatic single_engine_run(input bit is_write);
        t_mmio_data value;
        t_line_addr base;
        int count;
        int first;
        base = t_line_addr'($urandom) & 32'h0fff_ffff;
        count = 1 + int'($urandom % 8);
        first = host_mem_model_inst.seen_count;
        start_run(is_write, base, count);
        wait_done(CSR_TEST_BASE + (is_write ? TCSR_WR_CTRL : TCSR_RD_CTRL), count);
        check_log(is_write ? REQ_WRITE : REQ_READ, base, count, first);
        check("total_requests", 64'(host_mem_model_inst.seen_count - first), 64'(count));
        csr_read(CSR_TEST_BASE + (is_write ? TCSR_WR_BASE : TCSR_RD_BASE), value);
        check("base_readback", value, 64'(base));
    endtask

    task automatic concurrent_run();
        t_line_addr rd_base;
        t_line_addr wr_base;
        int rd_count;
        int wr_count;
        int first;
        rd_base = t_line_addr'($urandom) & 32'h0fff_ffff;
        rd_count = 1 + int'($urandom % 8);
        wr_base = t_line_addr'($urandom) & 32'h0fff_ffff;
        wr_count = 1 + int'($urandom % 8);
        first = host_mem_model_inst.seen_count;
        @(posedge clk);
        stress <= 1'b1;
        start_run(1'b0, rd_base, rd_count);
        start_run(1'b1, wr_base, wr_count);
        wait_done(CSR_TEST_BASE + TCSR_RD_CTRL, rd_count);
        wait_done(CSR_TEST_BASE + TCSR_WR_CTRL, wr_count);
        @(posedge clk);
        stress <= 1'b0;
        check_log(REQ_READ, rd_base, rd_count, first);
        check_log(REQ_WRITE, wr_base, wr_count, first);
        check("total_requests", 64'(host_mem_model_inst.seen_count - first),
              64'(rd_count + wr_count));
        check("almfull_violations", 64'(host_mem_model_inst.almfull_violations), 64'd0);
    endtask

    task automatic statistics_reads();
        t_mmio_data value;
        csr_read(CSR_RD_HIT, value);
        check("csr9", value, 64'(exp_rd_hit));
        csr_read(CSR_RD_MISS, value);
        check("csr10", value, 64'(exp_rd_miss));
        csr_read(CSR_WR_HIT, value);
        check("csr11", value, 64'(exp_wr_hit));
        csr_read(CSR_WR_MISS, value);
        check("csr12", value, 64'(exp_wr_miss));
        csr_read(CSR_VL0, value);
        check("csr13", value, 64'(exp_vl0));
    endtask

    initial
    begin
        void'($urandom(65629));
        reset = 1'b1;
        mmio_valid = 1'b0;
        mmio_write = 1'b0;
        mmio_addr = '0;
        mmio_tid = '0;
        mmio_wdata = '0;
        stress = 1'b0;
        next_tid = 9'h0a5;
        exp_rd_hit = 0;
        exp_rd_miss = 0;
        exp_wr_hit = 0;
        exp_wr_miss = 0;
        exp_vl0 = 0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        header_reads();
        // Reader run before the writer run
        single_engine_run(1'b0);
        single_engine_run(1'b1);
        concurrent_run();
        statistics_reads();

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
verilog/host_chan_pkg.sv
verilog/test_csr_pkg.sv
verilog/afu_ifs.sv
verilog/csr_manager.sv
verilog/traffic_engine.sv
verilog/request_arbiter.sv
verilog/afu_test_top.sv
tb/host_mem_model.sv
tb/afu_test_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := afu_test_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the pass line appears in the output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)
